/* Makefile */
VERILATOR ?= verilator
FILELIST ?= filelist.f
TB_TOP ?= tb_connect_four
RTL_TOP ?= connect_four
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT ?= sim passed
RTL_SRCS = $(filter design/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_connect_four.sv */
`timescale 1ns/1ps

module tb_connect_four
	import c4_pkg::*;
();

	localparam int CURSOR_PRESSES = 3;
	localparam int STACK_PRESSES = 9;
	// Scripted drops of the four games with up to seven moves before each
	localparam int GAME_DROPS = 36;
	localparam int GAME_PRESSES = GAME_DROPS * 8 + 4 * 2;
	localparam int RANDOM_PRESSES = 200;
	localparam int PLANNED_PRESSES =
		CURSOR_PRESSES + STACK_PRESSES + GAME_PRESSES + RANDOM_PRESSES;
	localparam int WATCHDOG_CYCLES = PLANNED_PRESSES * 50;

	localparam buttons_t PRESS_LEFT = '{1'b1, 1'b0, 1'b0};
	localparam buttons_t PRESS_RIGHT = '{1'b0, 1'b1, 1'b0};
	localparam buttons_t PRESS_BOTH = '{1'b1, 1'b1, 1'b0};
	localparam buttons_t PRESS_DROP = '{1'b0, 1'b0, 1'b1};

	logic                clk;
	logic                rst_n;
	buttons_t            buttons;
	board_t              board;
	logic [COL_BITS-1:0] current_col;
	player_e             current_player;
	logic                game_over;

	// Reference model state
	board_t                 m_board;
	logic [HEIGHT_BITS-1:0] m_height [COLS];
	logic [COL_BITS-1:0]    m_col;
	player_e                m_player;
	logic                   m_over;

	int          board_errs;
	int          player_errs;
	int          col_errs;
	int          flag_errs;
	logic [31:0] lfsr;
	event        compare_ev;

	connect_four u_connect_four (
		.clk            (clk),
		.rst_n          (rst_n),
		.buttons        (buttons),
		.board          (board),
		.current_col    (current_col),
		.current_player (current_player),
		.game_over      (game_over)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// Four or more of p in any line through the given cell
	function automatic logic makes_four(input board_t b, input int row, input int col,
		input player_e p);
		int dr;
		int dc;
		int r;
		int c;
		int count;
		logic found;
		found = 1'b0;
		for (int d = 0; d < 4; d++)
		begin
			dr = (d == 0) ? 0 : ((d == 3) ? -1 : 1);
			dc = (d == 1) ? 0 : 1;
			count = 1;
			r = row + dr;
			c = col + dc;
			while (r >= 0 && r < ROWS && c >= 0 && c < COLS
				&& b[r[ROW_BITS-1:0]][c[COL_BITS-1:0]] == p)
			begin
				count++;
				r += dr;
				c += dc;
			end
			r = row - dr;
			c = col - dc;
			while (r >= 0 && r < ROWS && c >= 0 && c < COLS
				&& b[r[ROW_BITS-1:0]][c[COL_BITS-1:0]] == p)
			begin
				count++;
				r -= dr;
				c -= dc;
			end
			if (count >= 4)
				found = 1'b1;
		end
		return found;
	endfunction

	task automatic reset_model;
		for (int c = 0; c < COLS; c++)
		begin
			m_height[c] = '0;
			for (int r = 0; r < ROWS; r++)
				m_board[r][c] = EMPTY;
		end
		m_col = '0;
		m_player = PLAYER1;
		m_over = 1'b0;
	endtask

	task automatic update_model(input buttons_t mask);
		int row;
		if (m_over)
			return;
		if (mask.drop)
		begin
			row = int'(m_height[m_col]);
			if (row < ROWS)
			begin
				m_board[row[ROW_BITS-1:0]][m_col] = m_player;
				m_height[m_col] = m_height[m_col] + 1'b1;
				if (makes_four(m_board, row, int'(m_col), m_player))
					m_over = 1'b1;
				else
					m_player = (m_player == PLAYER1) ? PLAYER2 : PLAYER1;
			end
		end
		else if (mask.move_left && !mask.move_right)
			m_col = m_col - 1'b1;
		else if (mask.move_right && !mask.move_left)
			m_col = m_col + 1'b1;
	endtask

	task automatic check_board(input board_t got, input board_t exp);
		if (got !== exp)
		begin
			$display("error at %0t: board is %h, expected %h", $time, got, exp);
			board_errs++;
		end
	endtask

	task automatic check_player(input player_e got, input player_e exp);
		if (got !== exp)
		begin
			$display("error at %0t: current_player is %s, expected %s",
				$time, got.name(), exp.name());
			player_errs++;
		end
	endtask

	task automatic check_col(input logic [COL_BITS-1:0] got, input logic [COL_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t: current_col is %0d, expected %0d", $time, got, exp);
			col_errs++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t: game_over is %b, expected %b", $time, got, exp);
			flag_errs++;
		end
	endtask

	always @(compare_ev)
	begin
		check_board(board, m_board);
		check_col(current_col, m_col);
		check_player(current_player, m_player);
		check_flag(game_over, m_over);
	end

	task automatic apply_reset;
		@(posedge clk);
		#1 rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		reset_model();
		repeat (2) @(posedge clk);
		#1;
		-> compare_ev;
	endtask

	// Button held low for four cycles and then released
	task automatic press(input buttons_t mask);
		int settle;
		settle = mask.drop ? 40 : 10;
		@(posedge clk);
		#1 buttons = buttons_t'(~mask);
		repeat (4) @(posedge clk);
		#1 buttons = '1;
		repeat (settle) @(posedge clk);
		#1;
		update_model(mask);
		-> compare_ev;
	endtask

	task automatic play_col(input int col);
		while (int'(m_col) != col)
			press(PRESS_RIGHT);
		press(PRESS_DROP);
	endtask

	// One column digit per drop with player 1 moving first and winning
	task automatic run_game(input string cols);
		apply_reset();
		for (int i = 0; i < cols.len(); i++)
			play_col(int'(cols[i]) - 48);
		check_flag(game_over, 1'b1);
		check_player(current_player, PLAYER1);
		press(PRESS_RIGHT);
		press(PRESS_DROP);
	endtask

	task automatic random_play;
		int pick;
		int count;
		apply_reset();
		count = 0;
		while (!m_over && count < RANDOM_PRESSES)
		begin
			take_bits(2, pick);
			case (pick)
				0: press(PRESS_LEFT);
				1: press(PRESS_RIGHT);
				default: press(PRESS_DROP);
			endcase
			count++;
		end
	endtask

	initial
	begin
		int total;
		rst_n = 1'b0;
		buttons = '1;
		lfsr = 32'h24f;
		board_errs = 0;
		player_errs = 0;
		col_errs = 0;
		flag_errs = 0;
		reset_model();
		apply_reset();
		// Wrap at both ends and then left and right at once
		press(PRESS_LEFT);
		press(PRESS_RIGHT);
		press(PRESS_BOTH);
		// Fill column 0 and drop once more into the full column
		repeat (STACK_PRESSES) press(PRESS_DROP);
		run_game("3434343");
		run_game("0011332");
		run_game("01222333361");
		run_game("32111000062");
		random_play();
		@(posedge clk);
		#1;
		total = board_errs + player_errs + col_errs + flag_errs;
		$display("errors: board %0d, player %0d, col %0d, flag %0d, total %0d",
			board_errs, player_errs, col_errs, flag_errs, total);
		if (total == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* design/board_store.sv */
`timescale 1ns/1ps

module board_store
	import c4_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   place,
	input  logic [COL_BITS-1:0]    cursor_col,
	input  player_e                player,
	output logic [HEIGHT_BITS-1:0] col_height,
	output logic                   col_full,
	output board_t                 board
);

	board_t cells;
	// Number of pieces already in each column
	logic [HEIGHT_BITS-1:0] heights [COLS];

	assign col_height = heights[cursor_col];
	assign col_full = (col_height == HEIGHT_BITS'(ROWS));
	assign board = cells;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int c = 0; c < COLS; c++)
			begin
				heights[c] <= '0;
				for (int r = 0; r < ROWS; r++)
				begin
					cells[r][c] <= EMPTY;
				end
			end
		end
		else if (place)
		begin
			// New piece lands on the lowest free cell
			cells[col_height[ROW_BITS-1:0]][cursor_col] <= player;
			heights[cursor_col] <= col_height + 1'b1;
		end
	end

endmodule

/* design/button_edge.sv */
`timescale 1ns/1ps

module button_edge
	import c4_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  buttons_t levels,
	output buttons_t presses
);

	buttons_t sync_0;
	buttons_t sync_1;
	buttons_t sync_2;
	buttons_t fall;

	// Press is a 1 to 0 step between the two oldest stages
	always_comb
	begin
		fall = buttons_t'(sync_2 & ~sync_1);
		// Left and right together cancel each other
		if (fall.move_left && fall.move_right)
		begin
			fall.move_left = 1'b0;
			fall.move_right = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_0 <= '1;
			sync_1 <= '1;
			sync_2 <= '1;
			presses <= '0;
		end
		else
		begin
			sync_0 <= levels;
			sync_1 <= sync_0;
			sync_2 <= sync_1;
			presses <= fall;
		end
	end

endmodule

/* design/c4_pkg.sv */
package c4_pkg;

	// Board geometry
	localparam int ROWS = 8;
	localparam int COLS = 8;
	localparam int ROW_BITS = 3;
	localparam int COL_BITS = 3;
	// One extra bit so a full column reads as 8
	localparam int HEIGHT_BITS = 4;
	localparam logic [COL_BITS-1:0] LAST_COL = 3'd7;

	// Cell contents and whose turn it is
	typedef enum logic [1:0] {
		EMPTY   = 2'b00,
		PLAYER1 = 2'b01,
		PLAYER2 = 2'b10
	} player_e;

	// Row 0 is the bottom row, cell [0][0] sits in the top bits
	typedef player_e [0:ROWS-1][0:COLS-1] board_t;

	typedef struct packed {
		logic [ROW_BITS-1:0] row;
		logic [COL_BITS-1:0] col;
	} cursor_t;

	typedef struct packed {
		logic move_left;
		logic move_right;
		logic drop;
	} buttons_t;

	typedef enum logic [1:0] {IDLE, PLACE, CHECK, WIN} game_state_e;

	// Scan order of the win check
	typedef enum logic [3:0] {
		START,
		DOWN,
		ROW_1, ROW_2, ROW_3, ROW_4,
		UP_1, UP_2, UP_3, UP_4,
		DN_1, DN_2, DN_3, DN_4,
		DONE
	} window_e;

endpackage

/* design/connect_four.sv */
`timescale 1ns/1ps

module connect_four
	import c4_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  buttons_t            buttons,
	output board_t              board,
	output logic [COL_BITS-1:0] current_col,
	output player_e             current_player,
	output logic                game_over
);

	buttons_t               presses;
	logic                   place;
	logic [HEIGHT_BITS-1:0] col_height;
	logic                   col_full;
	cursor_t                probe;
	window_e                window;
	logic                   hit;

	button_edge u_button_edge (
		.clk     (clk),
		.rst_n   (rst_n),
		.levels  (buttons),
		.presses (presses)
	);

	game_ctrl u_game_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.presses    (presses),
		.col_height (col_height),
		.col_full   (col_full),
		.hit        (hit),
		.place      (place),
		.cursor_col (current_col),
		.probe      (probe),
		.window     (window),
		.player     (current_player),
		.game_over  (game_over)
	);

	board_store u_board_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.place      (place),
		.cursor_col (current_col),
		.player     (current_player),
		.col_height (col_height),
		.col_full   (col_full),
		.board      (board)
	);

	window_check u_window_check (
		.board  (board),
		.probe  (probe),
		.player (current_player),
		.window (window),
		.hit    (hit)
	);

endmodule

/* design/game_ctrl.sv */
`timescale 1ns/1ps

module game_ctrl
	import c4_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  buttons_t               presses,
	input  logic [HEIGHT_BITS-1:0] col_height,
	input  logic                   col_full,
	input  logic                   hit,
	output logic                   place,
	output logic [COL_BITS-1:0]    cursor_col,
	output cursor_t                probe,
	output window_e                window,
	output player_e                player,
	output logic                   game_over
);

	game_state_e state;

	// Full columns never get a strobe
	assign place = (state == PLACE) && !col_full;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (presses.drop)
						state <= PLACE;
				PLACE:
					state <= col_full ? IDLE : CHECK;
				CHECK:
					if (window == DONE)
						state <= game_over ? WIN : IDLE;
				WIN:
					state <= WIN;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Cursor only moves while waiting for input
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cursor_col <= '0;
		else if (state == IDLE)
		begin
			if (presses.move_right)
				cursor_col <= (cursor_col == LAST_COL) ? '0 : cursor_col + 1'b1;
			else if (presses.move_left)
				cursor_col <= (cursor_col == '0) ? LAST_COL : cursor_col - 1'b1;
		end
	end

	// Cell that was just filled
	always_ff @(posedge clk)
	begin
		if (place)
		begin
			probe.row <= col_height[ROW_BITS-1:0];
			probe.col <= cursor_col;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			window <= START;
			player <= PLAYER1;
			game_over <= 1'b0;
		end
		else if (state == PLACE)
			window <= START;
		else if (state == CHECK)
		begin
			if (hit)
				game_over <= 1'b1;
			if (window != DONE)
				window <= window_e'(window + 4'd1);
			else if (!game_over)
				player <= (player == PLAYER1) ? PLAYER2 : PLAYER1;
		end
	end

endmodule

/* design/window_check.sv */
`timescale 1ns/1ps

module window_check
	import c4_pkg::*;
(
	input  board_t  board,
	input  cursor_t probe,
	input  player_e player,
	input  window_e window,
	output logic    hit
);

	always_comb
	begin : eval_window
		int off;
		int row0;
		int col0;
		int drow;
		int dcol;
		int row_k;
		int col_k;
		logic valid;
		logic fits;
		logic match;

		// How far the window starts before the probe
		case (window)
			ROW_1, UP_1, DN_1: off = 3;
			ROW_2, UP_2, DN_2: off = 2;
			ROW_3, UP_3, DN_3: off = 1;
			default: off = 0;
		endcase

		valid = 1'b1;
		row0 = int'(probe.row);
		col0 = int'(probe.col);
		drow = 0;
		dcol = 1;
		case (window)
			DOWN:
			begin
				drow = -1;
				dcol = 0;
			end
			ROW_1, ROW_2, ROW_3, ROW_4:
			begin
				col0 = int'(probe.col) - off;
			end
			UP_1, UP_2, UP_3, UP_4:
			begin
				row0 = int'(probe.row) - off;
				col0 = int'(probe.col) - off;
				drow = 1;
			end
			DN_1, DN_2, DN_3, DN_4:
			begin
				// Falling diagonal starts high on the left
				row0 = int'(probe.row) + off;
				col0 = int'(probe.col) - off;
				drow = -1;
			end
			default: valid = 1'b0;
		endcase

		// Both ends of the window must be on the board
		fits = valid
			&& (row0 >= 0) && (row0 < ROWS)
			&& (row0 + 3 * drow >= 0) && (row0 + 3 * drow < ROWS)
			&& (col0 >= 0) && (col0 + 3 * dcol < COLS);

		match = fits;
		for (int k = 0; k < 4; k++)
		begin
			row_k = row0 + k * drow;
			col_k = col0 + k * dcol;
			if (board[row_k[ROW_BITS-1:0]][col_k[COL_BITS-1:0]] != player)
				match = 1'b0;
		end
		hit = match;
	end

endmodule

/* filelist.f */
design/c4_pkg.sv
design/button_edge.sv
design/board_store.sv
design/window_check.sv
design/game_ctrl.sv
design/connect_four.sv
bench/tb_connect_four.sv
